// ==== rtl/fetch_pkg.sv ====
/* fetch front end shared definitions
   word types, fetch states, special instruction encodings and byte swap */
package fetch_pkg;

	localparam int xlen = 32;

	// queue depth used by the top level
	localparam int default_queue_depth_log2 = 4;

	typedef logic [xlen-1:0] data_t;

	typedef enum logic [1:0] {
		st_debug,
		st_fetch,
		st_stall,
		st_ecall_wait
	} fetch_state_t;

	// boot index is a word offset from here
	localparam data_t boot_base = 32'h0001_0000;

	localparam data_t ecall_word = 32'h0000_0073;

	// addi x0, x0, 0
	localparam data_t nop_word = 32'h0000_0013;

	typedef struct packed {
		data_t pc;
		data_t instr;
	} queue_entry_t;

	// memory holds little-endian words, the core wants them the other way round
	function automatic data_t swap_bytes(input data_t word);
		data_t swapped;
		swapped = {word[7:0], word[15:8], word[23:16], word[31:24]};
		return swapped;
	endfunction

endpackage : fetch_pkg

// ==== rtl/axil_rd_if.sv ====
/* AXI-Lite read address and read data channels */
`timescale 1ns/1ns

interface axil_rd_if;

	// read address channel
	fetch_pkg::data_t araddr;
	logic             arvalid;
	logic             arready;

	// read data channel
	fetch_pkg::data_t rdata;
	logic             rvalid;
	logic             rready;

	modport master (
		output araddr, arvalid, rready,
		input  arready, rdata, rvalid
	);

	modport slave (
		input  araddr, arvalid, rready,
		output arready, rdata, rvalid
	);

endinterface : axil_rd_if

// ==== rtl/axil_read_master.sv ====
/* AXI-Lite single word read master
   one AR/R transaction per request, done pulses with the R handshake */
`timescale 1ns/1ns

module axil_read_master (
	input  logic             clk,
	input  logic             rst_n,
	input  fetch_pkg::data_t addr,
	input  logic             rd,
	output fetch_pkg::data_t data,
	output logic             done,
	axil_rd_if.master        bus
);

	typedef enum logic {
		ph_addr,
		ph_data
	} phase_t;

	phase_t           phase;
	logic             arvalid_q;
	fetch_pkg::data_t araddr_q;
	logic             start;

	// a new request is only taken while idle in the address phase
	assign start = (phase == ph_addr) && !arvalid_q && rd;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase     <= ph_addr;
			arvalid_q <= 1'b0;
		end else begin
			unique case (phase)
				ph_addr: begin
					if (arvalid_q && bus.arready) begin
						arvalid_q <= 1'b0;
						phase     <= ph_data;
					end else if (start) begin
						arvalid_q <= 1'b1;
					end
				end
				ph_data: begin
					if (bus.rvalid)
						phase <= ph_addr;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start)
			araddr_q <= addr;
	end

	assign bus.araddr  = araddr_q;
	assign bus.arvalid = arvalid_q;
	assign bus.rready  = (phase == ph_data);

	// completion lines up with the R handshake
	assign done = (phase == ph_data) && bus.rvalid;
	assign data = bus.rdata;

	// address channel payload must not move before the slave takes it
	a_araddr_stable: assert property (
		@(posedge clk) disable iff (!rst_n)
		bus.arvalid && !bus.arready |=> bus.arvalid && $stable(bus.araddr)
	);

endmodule : axil_read_master

// ==== rtl/instr_queue.sv ====
/* instruction queue
   circular FIFO of pc/instruction pairs with registered read and almost-full flag */
`timescale 1ns/1ns

module instr_queue #(
	parameter int depth_log2 = fetch_pkg::default_queue_depth_log2
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    clear,
	input  logic                    wr_en,
	input  fetch_pkg::queue_entry_t din,
	input  logic                    rd_en,
	output fetch_pkg::queue_entry_t dout,
	output logic                    empty,
	output logic                    almost_full
);

	fetch_pkg::queue_entry_t mem [2**depth_log2];

	logic [depth_log2-1:0] wr_ptr;
	logic [depth_log2-1:0] rd_ptr;
	logic [depth_log2:0]   count;
	logic [depth_log2:0]   capacity;
	logic                  full;

	assign capacity = {1'b1, {depth_log2{1'b0}}};
	assign full     = (count == capacity);
	assign empty    = (count == '0);

	// two spare slots, one for the read in flight and one being written
	assign almost_full = (count >= capacity - 2'd2);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			unique case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en && !clear)
			mem[wr_ptr] <= din;
		if (rd_en)
			dout <= mem[rd_ptr];
	end

	// the fetch side throttles on almost_full, so these should never fire
	a_no_overflow: assert property (
		@(posedge clk) disable iff (!rst_n) !(wr_en && full)
	);

	a_no_underflow: assert property (
		@(posedge clk) disable iff (!rst_n) !(rd_en && empty)
	);

endmodule : instr_queue

// ==== rtl/fetch_unit.sv ====
/* instruction fetch unit
   fetch FSM, pc and flush control, instruction queue and output formatting */
`timescale 1ns/1ns

module fetch_unit #(
	parameter int queue_depth_log2 = fetch_pkg::default_queue_depth_log2
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             go,
	input  logic [9:0]       boot_index,
	input  logic             flush,
	input  fetch_pkg::data_t flush_pc,
	input  logic             stall,
	input  fetch_pkg::data_t retire_instr,
	output fetch_pkg::data_t instr,
	output fetch_pkg::data_t pc_out,
	output logic             instr_valid,
	axil_rd_if.master        bus
);

	fetch_pkg::fetch_state_t state;
	fetch_pkg::fetch_state_t state_next;

	fetch_pkg::data_t        pc;
	fetch_pkg::data_t        rd_data;
	fetch_pkg::queue_entry_t q_din;
	fetch_pkg::queue_entry_t q_dout;

	logic rd;
	logic done;
	logic accept;
	logic is_ecall;
	logic outstanding;
	logic flush_pending;
	logic flush_pending_q;
	logic q_rd;
	logic q_empty;
	logic q_almost_full;

	// a read is on the bus from the cycle after it was taken up to done
	assign outstanding = bus.arvalid || bus.rready;

	// no new read while a flush is being resolved
	assign rd = (state == fetch_pkg::st_fetch) && !q_almost_full && !flush && !flush_pending;

	// words completing under a flush belong to the old path
	assign accept   = done && !flush && !flush_pending;
	assign is_ecall = (fetch_pkg::swap_bytes(rd_data) == fetch_pkg::ecall_word);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			flush_pending   <= 1'b0;
			flush_pending_q <= 1'b0;
		end else begin
			if (done)
				flush_pending <= 1'b0;
			else if (flush && outstanding)
				flush_pending <= 1'b1;
			flush_pending_q <= flush_pending;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pc <= fetch_pkg::boot_base + {20'd0, boot_index, 2'b00};
		else if (flush)
			pc <= flush_pc;
		else if (accept)
			pc <= pc + 32'd4;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= fetch_pkg::st_debug;
		else
			state <= state_next;
	end

	always_comb begin
		state_next = state;
		unique case (state)
			fetch_pkg::st_debug: begin
				if (go)
					state_next = fetch_pkg::st_fetch;
			end
			fetch_pkg::st_fetch: begin
				if (accept && is_ecall)
					state_next = fetch_pkg::st_ecall_wait;
				else if (q_almost_full && !flush)
					state_next = fetch_pkg::st_stall;
			end
			// the last read may still land here
			fetch_pkg::st_stall: begin
				if (accept && is_ecall)
					state_next = fetch_pkg::st_ecall_wait;
				else if (flush || !q_almost_full)
					state_next = fetch_pkg::st_fetch;
			end
			fetch_pkg::st_ecall_wait: begin
				if (retire_instr == fetch_pkg::ecall_word)
					state_next = fetch_pkg::st_debug;
				else if (flush)
					state_next = fetch_pkg::st_fetch;
			end
			default: state_next = fetch_pkg::st_debug;
		endcase
	end

	axil_read_master u_read_master (
		.clk   (clk),
		.rst_n (rst_n),
		.addr  (pc),
		.rd    (rd),
		.data  (rd_data),
		.done  (done),
		.bus   (bus)
	);

	assign q_din = '{pc: pc, instr: rd_data};

	// hold off one more cycle after the stale word is dropped
	assign q_rd = !q_empty && !stall && !flush && !flush_pending && !flush_pending_q;

	instr_queue #(
		.depth_log2 (queue_depth_log2)
	) u_instr_queue (
		.clk         (clk),
		.rst_n       (rst_n),
		.clear       (flush),
		.wr_en       (accept),
		.din         (q_din),
		.rd_en       (q_rd),
		.dout        (q_dout),
		.empty       (q_empty),
		.almost_full (q_almost_full)
	);

	// follows the registered queue read by one cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			instr_valid <= 1'b0;
		else if (flush)
			instr_valid <= 1'b0;
		else if (!stall)
			instr_valid <= q_rd;
	end

	assign instr  = instr_valid ? fetch_pkg::swap_bytes(q_dout.instr) : fetch_pkg::nop_word;
	assign pc_out = instr_valid ? q_dout.pc : '0;

endmodule : fetch_unit

// ==== rtl/fetch_top.sv ====
/* fetch front end top level
   AXI-Lite read channels and core-side fetch ports as plain ports */
`timescale 1ns/1ns

module fetch_top (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             go,
	input  logic [9:0]       boot_index,
	input  logic             flush,
	input  fetch_pkg::data_t flush_pc,
	input  logic             stall,
	input  fetch_pkg::data_t retire_instr,
	output fetch_pkg::data_t instr,
	output fetch_pkg::data_t pc_out,
	output logic             instr_valid,
	output fetch_pkg::data_t axil_araddr,
	output logic             axil_arvalid,
	input  logic             axil_arready,
	input  fetch_pkg::data_t axil_rdata,
	input  logic             axil_rvalid,
	output logic             axil_rready
);

	axil_rd_if bus ();

	assign axil_araddr  = bus.araddr;
	assign axil_arvalid = bus.arvalid;
	assign axil_rready  = bus.rready;
	assign bus.arready  = axil_arready;
	assign bus.rdata    = axil_rdata;
	assign bus.rvalid   = axil_rvalid;

	fetch_unit #(
		.queue_depth_log2 (fetch_pkg::default_queue_depth_log2)
	) u_fetch_unit (
		.clk          (clk),
		.rst_n        (rst_n),
		.go           (go),
		.boot_index   (boot_index),
		.flush        (flush),
		.flush_pc     (flush_pc),
		.stall        (stall),
		.retire_instr (retire_instr),
		.instr        (instr),
		.pc_out       (pc_out),
		.instr_valid  (instr_valid),
		.bus          (bus)
	);

endmodule : fetch_top

// ==== tb/axil_rom_model.sv ====
/* AXI-Lite read slave model
   64-word ROM at boot_base with a pseudo-random response delay of 0 to 3 cycles */
`timescale 1ns/1ns

module axil_rom_model #(
	parameter logic [63:0] ecall_mask = '0,
	parameter logic [31:0] lfsr_seed  = 32'h7ab2
) (
	input  logic             clk,
	input  logic             rst_n,
	input  fetch_pkg::data_t araddr,
	input  logic             arvalid,
	output logic             arready,
	output fetch_pkg::data_t rdata,
	output logic             rvalid,
	input  logic             rready
);

	fetch_pkg::data_t rom [64];
	fetch_pkg::data_t init_word;
	fetch_pkg::data_t offset;
	logic [31:0]      lfsr;
	logic [31:0]      lfsr_once;
	logic [31:0]      lfsr_twice;
	logic [1:0]       wait_cnt;
	logic             busy;

	// galois form, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		if (state[0])
			return (state >> 1) ^ 32'h8020_0003;
		return state >> 1;
	endfunction

	// each word is its own index, stored little-endian
	initial begin
		for (int i = 0; i < 64; i++) begin
			init_word = ecall_mask[i] ? fetch_pkg::ecall_word : 32'(i);
			rom[i] = {init_word[7:0], init_word[15:8], init_word[23:16], init_word[31:24]};
		end
	end

	assign offset     = araddr - fetch_pkg::boot_base;
	assign arready    = !busy;
	assign lfsr_once  = lfsr_step(lfsr);
	assign lfsr_twice = lfsr_step(lfsr_once);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy     <= 1'b0;
			rvalid   <= 1'b0;
			rdata    <= '0;
			wait_cnt <= 2'd0;
			lfsr     <= lfsr_seed;
		end else if (!busy) begin
			if (arvalid) begin
				busy     <= 1'b1;
				// one lfsr step per delay bit
				wait_cnt <= {lfsr_once[0], lfsr[0]};
				lfsr     <= lfsr_twice;
				rdata    <= (offset < 32'd256) ? rom[offset[7:2]] : ~araddr;
			end
		end else if (!rvalid) begin
			if (wait_cnt == 2'd0)
				rvalid <= 1'b1;
			else
				wait_cnt <= wait_cnt - 2'd1;
		end else if (rready) begin
			rvalid <= 1'b0;
			busy   <= 1'b0;
		end
	end

endmodule : axil_rom_model

// ==== tb/fetch_tb.sv ====
/* fetch front end testbench
   phase table against a pc model, with stall, flush and ecall checks and a watchdog */
`timescale 1ns/1ns

module fetch_tb;

	localparam int num_rows      = 5;
	localparam int row_budget    = 200;
	localparam int clk_period    = 8;
	localparam int retire_cycles = 8;
	// ecalls at word indices 9, 30, 47 and 63
	localparam logic [63:0] ecall_mask = 64'h8000_8000_4000_0200;

	typedef struct packed {
		logic             do_reset;
		logic [9:0]       boot_index;
		logic             go;
		int               flush_at;
		fetch_pkg::data_t flush_target;
		int               stall_from;
		int               stall_len;
		int               n_expected;
		fetch_pkg::data_t first_pc;
	} phase_t;

	logic             clk;
	logic             rst_n;
	logic             go;
	logic [9:0]       boot_index;
	logic             flush;
	fetch_pkg::data_t flush_pc;
	logic             stall;
	fetch_pkg::data_t retire_instr;
	fetch_pkg::data_t instr;
	fetch_pkg::data_t pc_out;
	logic             instr_valid;
	fetch_pkg::data_t axil_araddr;
	logic             axil_arvalid;
	logic             axil_arready;
	fetch_pkg::data_t axil_rdata;
	logic             axil_rvalid;
	logic             axil_rready;

	phase_t           phases [num_rows];
	fetch_pkg::data_t expected_pc;
	fetch_pkg::data_t fetch_addr;
	fetch_pkg::data_t prev_instr;
	fetch_pkg::data_t prev_pc;
	logic             prev_valid;
	logic             prev_stall;
	logic             prev_flush;
	logic             ecall_seen;
	logic             read_open;
	int               delivered;
	int               cyc;

	fetch_top uut (
		.clk          (clk),
		.rst_n        (rst_n),
		.go           (go),
		.boot_index   (boot_index),
		.flush        (flush),
		.flush_pc     (flush_pc),
		.stall        (stall),
		.retire_instr (retire_instr),
		.instr        (instr),
		.pc_out       (pc_out),
		.instr_valid  (instr_valid),
		.axil_araddr  (axil_araddr),
		.axil_arvalid (axil_arvalid),
		.axil_arready (axil_arready),
		.axil_rdata   (axil_rdata),
		.axil_rvalid  (axil_rvalid),
		.axil_rready  (axil_rready)
	);

	axil_rom_model #(
		.ecall_mask (ecall_mask),
		.lfsr_seed  (32'h7ab2)
	) u_rom (
		.clk     (clk),
		.rst_n   (rst_n),
		.araddr  (axil_araddr),
		.arvalid (axil_arvalid),
		.arready (axil_arready),
		.rdata   (axil_rdata),
		.rvalid  (axil_rvalid),
		.rready  (axil_rready)
	);

	always #(clk_period / 2) clk = ~clk;

	task automatic flag_mismatch(input string what);
		$display("FAIL at %0t ns: %s", $time, what);
		$display("Test failed");
		$fatal(1, "value mismatch");
	endtask

	task automatic abort_run(input string what);
		$display("ERROR at %0t ns: %s", $time, what);
		$display("Test failed");
		$fatal(1, "run aborted");
	endtask

	// unswapped word the core should see for an address
	function automatic fetch_pkg::data_t expected_instr(input fetch_pkg::data_t addr);
		fetch_pkg::data_t idx;
		idx = (addr - fetch_pkg::boot_base) >> 2;
		if (idx < 32'd64 && ecall_mask[idx[5:0]])
			return fetch_pkg::ecall_word;
		return idx;
	endfunction

	// called at the falling edge where outputs are settled
	task automatic sample_outputs();
		assert (instr_valid || (instr == fetch_pkg::nop_word && pc_out == '0))
		else flag_mismatch($sformatf("idle outputs instr=%h pc_out=%h", instr, pc_out));
		if (prev_flush) begin
			assert (!instr_valid) else flag_mismatch("instr_valid still high after flush");
		end else if (prev_stall) begin
			assert (instr_valid == prev_valid && instr == prev_instr && pc_out == prev_pc)
			else flag_mismatch($sformatf("outputs moved under stall, pc_out %h -> %h",
				prev_pc, pc_out));
		end
		assert (!(ecall_seen && axil_arvalid && axil_arready))
		else flag_mismatch($sformatf("read of %h issued after ecall", axil_araddr));
		// rready stays up from the AR handshake until the read data arrives
		if (read_open) begin
			assert (axil_rready) else flag_mismatch("rready low while waiting for read data");
			if (axil_rvalid)
				read_open = 1'b0;
		end
		// reads go out in word order and restart at a flush target
		if (axil_arvalid && axil_arready) begin
			assert (axil_araddr == fetch_addr)
			else flag_mismatch($sformatf("araddr %h, expected %h", axil_araddr, fetch_addr));
			fetch_addr = fetch_addr + 32'd4;
			read_open  = 1'b1;
		end
		if (flush) begin
			expected_pc = flush_pc;
			fetch_addr  = flush_pc;
		end else if (instr_valid && !stall) begin
			assert (pc_out == expected_pc)
			else flag_mismatch($sformatf("pc_out %h, expected %h", pc_out, expected_pc));
			assert (instr == expected_instr(expected_pc))
			else flag_mismatch($sformatf("instr %h at %h, expected %h", instr, expected_pc,
				expected_instr(expected_pc)));
			if (expected_instr(expected_pc) == fetch_pkg::ecall_word)
				ecall_seen = 1'b1;
			expected_pc = expected_pc + 32'd4;
			delivered++;
		end
		prev_valid = instr_valid;
		prev_instr = instr;
		prev_pc    = pc_out;
		prev_stall = stall;
		prev_flush = flush;
	endtask

	task automatic apply_reset(input logic [9:0] index);
		@(posedge clk);
		rst_n      <= 1'b0;
		boot_index <= index;
		go         <= 1'b0;
		stall      <= 1'b0;
		flush      <= 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		assert (!axil_arvalid && !instr_valid && pc_out == '0 && instr == fetch_pkg::nop_word)
		else flag_mismatch("outputs not idle after reset");
		prev_valid = 1'b0;
		prev_stall = 1'b0;
		prev_flush = 1'b0;
		ecall_seen = 1'b0;
		read_open  = 1'b0;
		fetch_addr = fetch_pkg::boot_base + 32'd4 * 32'(index);
	endtask

	// the ecall retires and fetch must stay quiet until the next go
	task automatic retire_ecall();
		assert (ecall_seen) else abort_run("phase ended without delivering an ecall");
		@(posedge clk);
		stall        <= 1'b0;
		flush        <= 1'b0;
		go           <= 1'b0;
		retire_instr <= fetch_pkg::ecall_word;
		@(negedge clk);
		sample_outputs();
		@(posedge clk);
		retire_instr <= '0;
		repeat (retire_cycles) begin
			@(negedge clk);
			sample_outputs();
			assert (!instr_valid) else flag_mismatch("instr_valid came back after ecall retired");
		end
	endtask

	task automatic run_phase(input phase_t p);
		if (p.do_reset)
			apply_reset(p.boot_index);
		expected_pc = p.first_pc;
		delivered   = 0;
		cyc         = 0;
		while (delivered < p.n_expected) begin
			@(posedge clk);
			go       <= p.go && (cyc == 0);
			stall    <= (cyc >= p.stall_from) && (cyc < p.stall_from + p.stall_len);
			flush    <= (cyc == p.flush_at);
			flush_pc <= p.flush_target;
			if (p.go && cyc == 0)
				ecall_seen = 1'b0;
			@(negedge clk);
			sample_outputs();
			cyc++;
		end
		retire_ecall();
	endtask

	initial begin
		clk          = 1'b0;
		rst_n        = 1'b0;
		go           = 1'b0;
		boot_index   = '0;
		flush        = 1'b0;
		flush_pc     = '0;
		stall        = 1'b0;
		retire_instr = '0;
		prev_valid   = 1'b0;
		prev_instr   = '0;
		prev_pc      = '0;
		prev_stall   = 1'b0;
		prev_flush   = 1'b0;
		ecall_seen   = 1'b0;
		read_open    = 1'b0;
		fetch_addr   = '0;
		// reset, boot_index, go, flush cycle, flush target, stall from, stall length,
		// instructions expected, first pc
		phases[0] = '{1'b1, 10'd2, 1'b1, -1, 32'd0, 0, 0, 8, fetch_pkg::boot_base + 32'd8};
		phases[1] = '{1'b0, 10'd2, 1'b1, -1, 32'd0, 2, 100, 21, fetch_pkg::boot_base + 32'd40};
		phases[2] = '{1'b0, 10'd2, 1'b1, 12, fetch_pkg::boot_base + 32'd160, 0, 16, 8,
			fetch_pkg::boot_base + 32'd160};
		phases[3] = '{1'b0, 10'd2, 1'b1, -1, 32'd0, 10, 6, 16, fetch_pkg::boot_base + 32'd192};
		phases[4] = '{1'b1, 10'd20, 1'b1, -1, 32'd0, 0, 0, 11, fetch_pkg::boot_base + 32'd80};
		for (int r = 0; r < num_rows; r++)
			run_phase(phases[r]);
		$display("Test completed successfully");
		$finish;
	end

	// budget of row_budget cycles for every phase of the table
	initial begin
		#(num_rows * row_budget * clk_period);
		$display("ERROR: timeout, expected instructions did not arrive within %0d cycles",
			num_rows * row_budget);
		$display("Test failed");
		$fatal(1, "watchdog expired");
	end

endmodule : fetch_tb

// ==== build.f ====
rtl/fetch_pkg.sv
rtl/axil_rd_if.sv
rtl/axil_read_master.sv
rtl/instr_queue.sv
rtl/fetch_unit.sv
rtl/fetch_top.sv
tb/axil_rom_model.sv
tb/fetch_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fetch front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module fetch_tb \
	-Mdir obj_dir -o fetch_sim -f build.f

status=0
./obj_dir/fetch_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Test failed" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "Test completed successfully" sim.log; then
	echo "simulation did not finish cleanly (exit status $status)"
	exit 1
fi
exit 0
